// ==== Bender.yml ====
package:
  name: rv32_frontend

export_include_dirs:
  - include

sources:
  - files:
      - verilog/rv32_pkg.sv
      - verilog/fetch_ctrl.sv
      - verilog/pc_counter.sv
      - verilog/inst_decode.sv
      - verilog/inst_queue.sv
      - verilog/rename_map.sv
      - verilog/frontend_top.sv
  - target: test
    files:
      - tests/frontend_assert.sv
      - tests/tb_frontend.sv

// ==== compile.f ====
+incdir+include
verilog/rv32_pkg.sv
verilog/fetch_ctrl.sv
verilog/pc_counter.sv
verilog/inst_decode.sv
verilog/inst_queue.sv
verilog/rename_map.sv
verilog/frontend_top.sv
tests/frontend_assert.sv
tests/tb_frontend.sv

// ==== include/frontend_params.svh ====
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// First fetch address after reset
`define FE_RESET_PC 32'h0000_1000

// Decoded instruction queue entries
`define FE_QUEUE_DEPTH 4

// Physical registers, the low 32 hold the reset mapping
`define FE_PHYS_REGS 64

// Physical tag width follows the register count
`define FE_PHYS_TAG_W $clog2(`FE_PHYS_REGS)

// Cycle bound for any wait on the memory or the rename output
`define FE_MEM_TIMEOUT 200

`endif

// ==== tests/frontend_assert.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module frontend_assert (
    input logic clk,
    input logic rst,
    input logic imem_read,
    input logic imem_resp,
    input logic q_full,
    input logic q_empty,
    input logic q_pop,
    input logic ren_valid
);

    // Open request between a read strobe and its response
    logic pending;

    // Queue occupancy rebuilt from the push and pop strobes
    int occ;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (imem_read) begin
            pending <= 1'b1;
        end else if (imem_resp) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occ <= 0;
        end else if (imem_resp && !q_pop) begin
            occ <= occ + 1;
        end else if (q_pop && !imem_resp) begin
            occ <= occ - 1;
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        imem_read |-> !pending)
        else $error("imem_read while a response is still pending");

    a_resp_in_time: assert property (@(posedge clk) disable iff (rst)
        imem_read |-> ##[1:`FE_MEM_TIMEOUT] imem_resp)
        else $error("no imem_resp after imem_read");

    // Response is pushed into the queue on arrival
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        imem_resp |-> !q_full)
        else $error("queue push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        q_pop |-> occ != 0)
        else $error("queue pop with no entry pushed and not yet popped");

    a_flags_match: assert property (@(posedge clk) disable iff (rst)
        (q_empty == (occ == 0)) && (q_full == (occ == `FE_QUEUE_DEPTH)))
        else $error("queue flags disagree with the queue occupancy");

    a_reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !ren_valid)
        else $error("ren_valid high during reset");

endmodule

bind frontend_top frontend_assert u_frontend_assert (
    .clk       (clk),
    .rst       (rst),
    .imem_read (imem_read),
    .imem_resp (imem_resp),
    .q_full    (q_full),
    .q_empty   (q_empty),
    .q_pop     (q_pop),
    .ren_valid (ren_valid)
);

// ==== tests/tb_frontend.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module tb_frontend
    import rv32_pkg::*;
();

    localparam int PROG_LEN  = 128;
    localparam int N_CHECK   = 96;
    localparam int N_TESTS   = 5;
    localparam int QUIET_CYC = 20;

    logic          clk;
    logic          rst;
    logic [31:0]   imem_addr;
    logic          imem_read;
    logic [31:0]   imem_rdata;
    logic          imem_resp;
    logic          ren_valid;
    renamed_inst_t ren_inst;
    logic          free_valid;
    phys_tag_t     free_tag;

    // Program, memory model and reference state
    logic [15:0]   lfsr;
    logic [31:0]   prog [PROG_LEN];
    phys_tag_t     model_rat [32];
    phys_tag_t     model_fl [$];
    phys_tag_t     freed_q [$];
    logic          free_enable;
    logic          mem_busy;
    logic [1:0]    mem_wait;
    logic [31:0]   mem_addr;
    logic          read_seen;
    logic [31:0]   first_addr;
    int            checked;
    int            alloc_count;
    int            errors [N_TESTS];
    bit            timed_out;
    string         test_names [N_TESTS] = '{"reset_state", "fetch_order", "decode",
                                            "rename", "free_list_exhaustion"};

    frontend_top u_frontend_top (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_read  (imem_read),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp),
        .ren_valid  (ren_valid),
        .ren_inst   (ren_inst),
        .free_valid (free_valid),
        .free_tag   (free_tag)
    );

    always #50 clk = ~clk;

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One step per bit, newest bit at the bottom
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic build_program();
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] f3;
        logic [31:0] imm12;
        logic [31:0] imm20;
        for (int i = 0; i < PROG_LEN; i++) begin
            take_bits(5, rd);
            take_bits(5, rs1);
            take_bits(5, rs2);
            take_bits(3, f3);
            take_bits(12, imm12);
            take_bits(20, imm20);
            // Sprinkle some x0 destinations
            if (i % 11 == 7) begin
                rd = '0;
            end
            case (i % 6)
                0: prog[i] = {7'b0000000, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
                1: prog[i] = {imm12[11:0], rs1[4:0], f3[2:0], rd[4:0], OP_IMM};
                2: prog[i] = {imm12[11:0], rs1[4:0], 3'b010, rd[4:0], LOAD};
                3: prog[i] = {imm12[11:5], rs2[4:0], rs1[4:0], 3'b010, imm12[4:0], STORE};
                4: prog[i] = {imm20[19:0], rd[4:0], LUI};
                default: prog[i] = {imm20[19:0], rd[4:0], AUIPC};
            endcase
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        logic [11:0] fill;
        idx  = (addr - `FE_RESET_PC) >> 2;
        fill = addr[31:20] ^ addr[19:8] ^ {addr[7:0], 4'h0};
        if (idx < PROG_LEN) begin
            return prog[idx];
        end else begin
            // Outside the program, addi x0 with an address-folded immediate
            return {fill, 5'd0, 3'b000, 5'd0, OP_IMM};
        end
    endfunction

    // Expected rename result from the RV32I field layout and the model state
    function automatic renamed_inst_t ref_rename(input logic [31:0] addr,
                                                 input logic [31:0] word,
                                                 input logic [31:0] ord);
        renamed_inst_t r;
        r              = '0;
        r.dec.pc       = addr;
        r.dec.order    = ord;
        r.dec.opcode   = opcode_e'(word[6:0]);
        case (word[6:0])
            OP: begin
                r.dec.fmt       = FMT_R;
                r.dec.rs1       = word[19:15];
                r.dec.rs2       = word[24:20];
                r.dec.rd        = word[11:7];
                r.dec.uses_rs1  = 1'b1;
                r.dec.uses_rs2  = 1'b1;
                r.dec.writes_rd = 1'b1;
            end
            OP_IMM, LOAD: begin
                r.dec.fmt       = FMT_I;
                r.dec.rs1       = word[19:15];
                r.dec.rd        = word[11:7];
                r.dec.uses_rs1  = 1'b1;
                r.dec.writes_rd = 1'b1;
                r.dec.imm       = {{20{word[31]}}, word[31:20]};
            end
            STORE: begin
                r.dec.fmt      = FMT_S;
                r.dec.rs1      = word[19:15];
                r.dec.rs2      = word[24:20];
                r.dec.uses_rs1 = 1'b1;
                r.dec.uses_rs2 = 1'b1;
                r.dec.imm      = {{20{word[31]}}, word[31:25], word[11:7]};
            end
            LUI, AUIPC: begin
                r.dec.fmt       = FMT_U;
                r.dec.rd        = word[11:7];
                r.dec.writes_rd = 1'b1;
                r.dec.imm       = {word[31:12], 12'b0};
            end
            default: r.dec.fmt = FMT_R;
        endcase
        // x0 and unused sources read tag 0
        if (r.dec.uses_rs1 && r.dec.rs1 != 5'd0) begin
            r.ps1 = model_rat[r.dec.rs1];
        end
        if (r.dec.uses_rs2 && r.dec.rs2 != 5'd0) begin
            r.ps2 = model_rat[r.dec.rs2];
        end
        if (r.dec.writes_rd && r.dec.rd != 5'd0) begin
            r.old_pd = model_rat[r.dec.rd];
            r.pd     = (model_fl.size() > 0) ? model_fl[0] : '0;
        end
        return r;
    endfunction

    task automatic check_decoded(input int t, input string what,
                                 input decoded_inst_t exp, input decoded_inst_t act);
        if (act !== exp) begin
            errors[t]++;
            $display("Mismatch %s %s: expected %h actual %h", test_names[t], what, exp, act);
        end
    endtask

    task automatic check_tags(input int t, input string what,
                              input phys_tag_t exp, input phys_tag_t act);
        if (act !== exp) begin
            errors[t]++;
            $display("Mismatch %s %s: expected %0d actual %0d", test_names[t], what, exp, act);
        end
    endtask

    task automatic check_word(input int t, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors[t]++;
            $display("Mismatch %s %s: expected %h actual %h", test_names[t], what, exp, act);
        end
    endtask

    task automatic check_flag(input int t, input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors[t]++;
            $display("Mismatch %s %s: expected %b actual %b", test_names[t], what, exp, act);
        end
    endtask

    // Memory answers each read after 1 to 4 cycles
    always @(posedge clk) begin : mem_model
        logic [31:0] d;
        imem_resp <= 1'b0;
        if (mem_busy) begin
            if (mem_wait == 2'd0) begin
                imem_resp  <= 1'b1;
                imem_rdata <= fetch_word(mem_addr);
                mem_busy   <= 1'b0;
            end else begin
                mem_wait <= mem_wait - 2'd1;
            end
        end else if (!rst && imem_read) begin
            take_bits(2, d);
            mem_busy <= 1'b1;
            mem_wait <= d[1:0];
            mem_addr <= imem_addr;
            if (!read_seen) begin
                read_seen  <= 1'b1;
                first_addr <= imem_addr;
            end
        end
    end

    // Old tags go back one per cycle once freeing is on
    always @(posedge clk) begin
        if (rst || !free_enable || freed_q.size() == 0) begin
            free_valid <= 1'b0;
        end else begin
            free_valid <= 1'b1;
            free_tag   <= freed_q[0];
            model_fl.push_back(freed_q[0]);
            void'(freed_q.pop_front());
        end
    end

    // Mid-cycle compare of each renamed instruction
    always @(negedge clk) begin : compare
        renamed_inst_t exp;
        logic [31:0]   addr;
        if (!rst && ren_valid && checked < N_CHECK) begin
            addr = `FE_RESET_PC + 32'(checked) * 32'd4;
            check_word(1, "pc", addr, ren_inst.dec.pc);
            check_word(1, "order", 32'(checked), ren_inst.dec.order);
            exp = ref_rename(addr, prog[checked], 32'(checked));
            check_decoded(2, $sformatf("instruction %0d", checked), exp.dec, ren_inst.dec);
            check_tags(3, $sformatf("ps1 of instruction %0d", checked), exp.ps1, ren_inst.ps1);
            check_tags(3, $sformatf("ps2 of instruction %0d", checked), exp.ps2, ren_inst.ps2);
            check_tags(3, $sformatf("pd of instruction %0d", checked), exp.pd, ren_inst.pd);
            check_tags(3, $sformatf("old_pd of instruction %0d", checked),
                       exp.old_pd, ren_inst.old_pd);
            if (exp.dec.writes_rd && exp.dec.rd != 5'd0) begin
                if (model_fl.size() == 0) begin
                    errors[4]++;
                    $display("Instruction %0d renamed although no free register was left",
                             checked);
                end else begin
                    void'(model_fl.pop_front());
                end
                model_rat[exp.dec.rd] = exp.pd;
                freed_q.push_back(exp.old_pd);
                alloc_count++;
            end
            checked++;
        end
    end

    task automatic wait_first_read();
        int cycles;
        cycles = 0;
        while (!read_seen && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles >= `FE_MEM_TIMEOUT) begin
                timed_out = 1'b1;
                $display("Timeout: no instruction fetch after reset");
            end
        end
    endtask

    // Times out only when output stops making progress
    task automatic wait_progress(input int allocs, input int count, input string what);
        int idle;
        int last;
        idle = 0;
        last = checked;
        while (!timed_out && (alloc_count < allocs || checked < count)) begin
            @(posedge clk);
            if (checked != last) begin
                last = checked;
                idle = 0;
            end else begin
                idle++;
                if (idle >= `FE_MEM_TIMEOUT) begin
                    timed_out = 1'b1;
                    $display("Timeout: no renamed instruction while waiting for %s", what);
                end
            end
        end
    endtask

    task automatic wait_quiet();
        int idle;
        int cycles;
        int last;
        idle   = 0;
        cycles = 0;
        last   = checked;
        while (!timed_out && idle < QUIET_CYC) begin
            @(posedge clk);
            cycles++;
            idle = (checked != last) ? 0 : idle + 1;
            last = checked;
            if (cycles >= `FE_MEM_TIMEOUT && idle < QUIET_CYC) begin
                timed_out = 1'b1;
                $display("Timeout: renaming kept going with an empty free list");
            end
        end
    endtask

    initial begin : main
        renamed_inst_t head_exp;
        int            total;
        clk         = 1'b0;
        rst         = 1'b1;
        imem_rdata  = '0;
        imem_resp   = 1'b0;
        free_valid  = 1'b0;
        free_tag    = '0;
        free_enable = 1'b0;
        mem_busy    = 1'b0;
        mem_wait    = '0;
        mem_addr    = '0;
        read_seen   = 1'b0;
        first_addr  = '0;
        checked     = 0;
        alloc_count = 0;
        timed_out   = 1'b0;
        lfsr        = 16'd27322;
        foreach (errors[i]) errors[i] = 0;
        // Identity map, free list 32 up to 63
        for (int i = 0; i < 32; i++) begin
            model_rat[i] = phys_tag_t'(i);
            model_fl.push_back(phys_tag_t'(i + 32));
        end
        build_program();

        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_flag(0, "imem_read in reset", 1'b0, imem_read);
            check_flag(0, "ren_valid in reset", 1'b0, ren_valid);
        end
        @(posedge clk);
        rst <= 1'b0;
        wait_first_read();
        check_word(0, "first imem_addr", `FE_RESET_PC, first_addr);
        $display("%-22s %0d errors", test_names[0], errors[0]);

        // Nothing freed yet, rename must stop after 32 allocations
        wait_progress(32, 0, "32 destination allocations");
        wait_quiet();
        if (!timed_out) begin
            check_word(4, "allocations before the stall", 32'd32, 32'(alloc_count));
            head_exp = ref_rename(`FE_RESET_PC + 32'(checked) * 32'd4, prog[checked],
                                  32'(checked));
            check_flag(4, "stalled head writes a register", 1'b1,
                       head_exp.dec.writes_rd && head_exp.dec.rd != 5'd0);
        end
        free_enable <= 1'b1;
        wait_progress(0, N_CHECK, "the whole program");

        total = 0;
        for (int t = 1; t < N_TESTS; t++) begin
            $display("%-22s %0d errors", test_names[t], errors[t]);
        end
        foreach (errors[t]) total += errors[t];
        $display("Checked %0d instructions, %0d allocations, %0d errors, timeout %0d",
                 checked, alloc_count, total, timed_out);
        if (total == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic q_full,
    input  logic imem_resp,
    output logic imem_read
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } state_e;

    state_e state;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // WAIT stands for the one queue slot promised to the outstanding request
    // Issue only with no promise open and a free slot, so the answer always lands
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (!q_full) begin
                    state_next = REQ;
                end
            end
            // Queue may have filled with the last answer, back off then
            REQ: begin
                state_next = q_full ? IDLE : WAIT;
            end
            // Straight back to REQ so the next read follows the response
            WAIT: begin
                if (imem_resp) begin
                    state_next = REQ;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // Single-cycle read strobe
    assign imem_read = (state == REQ) && !q_full;

endmodule

// ==== verilog/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top
    import rv32_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    output logic [31:0]   imem_addr,
    output logic          imem_read,
    input  logic [31:0]   imem_rdata,
    input  logic          imem_resp,
    output logic          ren_valid,
    output renamed_inst_t ren_inst,
    input  logic          free_valid,
    input  phys_tag_t     free_tag
);

    logic          q_full;
    logic          q_empty;
    logic          q_pop;
    logic [31:0]   order;
    decoded_inst_t dec_inst;
    decoded_inst_t q_head;

    fetch_ctrl u_fetch_ctrl (
        .clk       (clk),
        .rst       (rst),
        .q_full    (q_full),
        .imem_resp (imem_resp),
        .imem_read (imem_read)
    );

    // Current pc is the address of the outstanding read
    pc_counter u_pc_counter (
        .clk     (clk),
        .rst     (rst),
        .advance (imem_resp),
        .pc      (imem_addr),
        .order   (order)
    );

    inst_decode u_inst_decode (
        .word  (imem_rdata),
        .pc    (imem_addr),
        .order (order),
        .dec   (dec_inst)
    );

    // Response is pushed on the same edge the pc moves on
    inst_queue u_inst_queue (
        .clk   (clk),
        .rst   (rst),
        .push  (imem_resp),
        .in    (dec_inst),
        .pop   (q_pop),
        .out   (q_head),
        .full  (q_full),
        .empty (q_empty)
    );

    rename_map u_rename_map (
        .clk        (clk),
        .rst        (rst),
        .q_empty    (q_empty),
        .head       (q_head),
        .pop        (q_pop),
        .free_valid (free_valid),
        .free_tag   (free_tag),
        .ren_valid  (ren_valid),
        .ren_inst   (ren_inst)
    );

endmodule

// ==== verilog/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode
    import rv32_pkg::*;
(
    input  inst_word_u    word,
    input  logic [31:0]   pc,
    input  logic [31:0]   order,
    output decoded_inst_t dec
);

    opcode_e opc;

    // Opcode sits at the same bits in every view
    assign opc = opcode_e'(word.r.opcode);

    always_comb begin
        dec        = '0;
        dec.pc     = pc;
        dec.order  = order;
        dec.opcode = opc;
        case (opc)
            OP: begin
                dec.fmt       = FMT_R;
                dec.rs1       = word.r.rs1;
                dec.rs2       = word.r.rs2;
                dec.rd        = word.r.rd;
                dec.uses_rs1  = 1'b1;
                dec.uses_rs2  = 1'b1;
                dec.writes_rd = 1'b1;
            end
            // Loads share the I layout with register-immediate ALU ops
            OP_IMM, LOAD: begin
                dec.fmt       = FMT_I;
                dec.rs1       = word.i.rs1;
                dec.rd        = word.i.rd;
                dec.uses_rs1  = 1'b1;
                dec.writes_rd = 1'b1;
                dec.imm       = {{20{word.i.imm[11]}}, word.i.imm};
            end
            STORE: begin
                dec.fmt      = FMT_S;
                dec.rs1      = word.s.rs1;
                dec.rs2      = word.s.rs2;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.imm      = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
            end
            // Upper immediate, low 12 bits zero
            LUI, AUIPC: begin
                dec.fmt       = FMT_U;
                dec.rd        = word.u.rd;
                dec.writes_rd = 1'b1;
                dec.imm       = {word.u.imm, 12'b0};
            end
            // Unknown opcode passes through as a no-op
            default: dec.fmt = FMT_R;
        endcase
    end

endmodule

// ==== verilog/inst_queue.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module inst_queue
    import rv32_pkg::*;
#(
    parameter int DEPTH = `FE_QUEUE_DEPTH
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  decoded_inst_t in,
    input  logic          pop,
    output decoded_inst_t out,
    output logic          full,
    output logic          empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST  = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] LIMIT = CNT_W'(DEPTH);

    decoded_inst_t    mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == LIMIT);
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head entry is visible without a pop
    assign out = mem[head];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail] <= in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= (tail == LAST) ? '0 : tail + 1'b1;
            end
            if (do_pop) begin
                head <= (head == LAST) ? '0 : head + 1'b1;
            end
            // Push and pop together leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/pc_counter.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module pc_counter (
    input  logic        clk,
    input  logic        rst,
    input  logic        advance,
    output logic [31:0] pc,
    output logic [31:0] order
);

    // Fetch address doubles as the memory address
    // Order counts accepted responses, one per instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= `FE_RESET_PC;
            order <= '0;
        end else if (advance) begin
            // No branches, always the next word
            pc    <= pc + 32'd4;
            order <= order + 32'd1;
        end
    end

endmodule

// ==== verilog/rename_map.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module rename_map
    import rv32_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          q_empty,
    input  decoded_inst_t head,
    output logic          pop,
    input  logic          free_valid,
    input  phys_tag_t     free_tag,
    output logic          ren_valid,
    output renamed_inst_t ren_inst
);

    localparam int FL_DEPTH = `FE_PHYS_REGS - 32;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);
    localparam int FL_CNT_W = $clog2(FL_DEPTH + 1);
    localparam logic [FL_PTR_W-1:0] FL_LAST  = FL_PTR_W'(FL_DEPTH - 1);
    localparam logic [FL_CNT_W-1:0] FL_LIMIT = FL_CNT_W'(FL_DEPTH);

    phys_tag_t           rat [32];
    phys_tag_t           fl_mem [FL_DEPTH];
    logic [FL_PTR_W-1:0] fl_head;
    logic [FL_PTR_W-1:0] fl_tail;
    logic [FL_CNT_W-1:0] fl_count;
    logic                need_pd;
    logic                alloc;
    logic                fl_push;
    renamed_inst_t       ren_next;

    // x0 never gets a new tag
    assign need_pd = head.writes_rd && (head.rd != 5'd0);
    // Stall on the head when it needs a tag and none is free
    assign pop     = !q_empty && (!need_pd || (fl_count != '0));
    assign alloc   = pop && need_pd;
    assign fl_push = free_valid && (fl_count != FL_LIMIT);

    // Sources read the table before this instruction's own update
    // Entry 0 keeps tag 0, so an x0 source needs no extra check
    always_comb begin
        ren_next        = '0;
        ren_next.dec    = head;
        ren_next.ps1    = head.uses_rs1 ? rat[head.rs1] : '0;
        ren_next.ps2    = head.uses_rs2 ? rat[head.rs2] : '0;
        ren_next.pd     = need_pd ? fl_mem[fl_head] : '0;
        ren_next.old_pd = need_pd ? rat[head.rd] : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map, free list holds 32 and up in order
            for (int i = 0; i < 32; i++) begin
                rat[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= phys_tag_t'(i + 32);
            end
            fl_head   <= '0;
            fl_tail   <= '0;
            fl_count  <= FL_LIMIT;
            ren_valid <= 1'b0;
        end else begin
            ren_valid <= pop;
            // Freed tags go to the tail, reused oldest first
            if (fl_push) begin
                fl_mem[fl_tail] <= free_tag;
                fl_tail         <= (fl_tail == FL_LAST) ? '0 : fl_tail + 1'b1;
            end
            if (alloc) begin
                rat[head.rd] <= fl_mem[fl_head];
                fl_head      <= (fl_head == FL_LAST) ? '0 : fl_head + 1'b1;
            end
            if (fl_push && !alloc) begin
                fl_count <= fl_count + 1'b1;
            end else if (alloc && !fl_push) begin
                fl_count <= fl_count - 1'b1;
            end
        end
    end

    // Output payload, valid one cycle after the pop
    always_ff @(posedge clk) begin
        if (pop) begin
            ren_inst <= ren_next;
        end
    end

endmodule

// ==== verilog/rv32_pkg.sv ====
`include "frontend_params.svh"

package rv32_pkg;

    // RV32I major opcodes handled by the front end
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // Immediate layout selector
    typedef enum logic [1:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_U
    } fmt_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Store immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One fetched word, four views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } inst_word_u;

    typedef logic [`FE_PHYS_TAG_W-1:0] phys_tag_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] order;
        opcode_e     opcode;
        fmt_e        fmt;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        uses_rs1;
        logic        uses_rs2;
        logic        writes_rd;
        logic [31:0] imm;
    } decoded_inst_t;

    typedef struct packed {
        decoded_inst_t dec;
        phys_tag_t     ps1;
        phys_tag_t     ps2;
        phys_tag_t     pd;
        phys_tag_t     old_pd;
    } renamed_inst_t;

endpackage
